// File: hw/bus_pkg.sv
package bus_pkg;

    // symbols handed to the bit engine one per SCL period
    typedef enum logic [1:0]
    {
        SYM_START,
        SYM_STOP,
        SYM_TX,
        SYM_RX
    } bit_sym_t;

    // 24C16 device type code in the top nibble of the control byte
    parameter logic [3:0] DEV_CODE = 4'b1010;

    // 2 Kbyte array
    parameter int ADDR_W = 11;

    parameter int DATA_W = 8;

endpackage

// File: hw/ctrl_pkg.sv
package ctrl_pkg;

    // byte level work for the shifter
    typedef enum logic [1:0]
    {
        OP_START,
        OP_STOP,
        OP_SEND,
        OP_RECV
    } byte_op_t;

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA_W,
        ST_RESTART,   // repeated start of a random read
        ST_CTRL_R,
        ST_DATA_R,
        ST_STOP,
        ST_DONE
    } main_state_t;

endpackage

// File: hw/eeprom_ifs.sv
`timescale 1ns/100ps

// byte operations from controller to shifter
interface byte_if;
    logic                           go;
    ctrl_pkg::byte_op_t             op;
    logic [bus_pkg::DATA_W-1:0]     tx_byte;
    logic                           last;     // answer the received byte with nack
    logic                           done;
    logic [bus_pkg::DATA_W-1:0]     rx_byte;
    logic                           ack_bit;  // 0 = slave acked

    modport ctrl (output go, op, tx_byte, last, input done, rx_byte, ack_bit);
    modport shifter (input go, op, tx_byte, last, output done, rx_byte, ack_bit);
endinterface

// single bit symbols from shifter to bit engine
interface bit_if;
    logic                   go;
    bus_pkg::bit_sym_t      sym;
    logic                   tx_bit;
    logic                   done;
    logic                   rx_bit;

    modport shifter (output go, sym, tx_bit, input done, rx_bit);
    modport engine (input go, sym, tx_bit, output done, rx_bit);
endinterface

// File: hw/bit_engine.sv
`timescale 1ns/100ps

module bit_engine
#(
    parameter int CLK_DIV = 2
)
(
    input  logic        CLK,
    input  logic        RESET,
    bit_if.engine       bus,
    output logic        scl,
    output logic        sda_low,
    input  logic        sda_in
);

    localparam int DIV_W = $clog2(CLK_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);

    logic               active;
    logic [1:0]         phase;     // quarter of the SCL period
    logic [DIV_W-1:0]   div;
    bus_pkg::bit_sym_t  sym_q;
    logic               tx_q;
    logic               scl_nxt;
    logic               sda_nxt;

    // line levels held unless a symbol runs
    always_comb
    begin
        scl_nxt = scl;
        sda_nxt = sda_low;
        if (active)
        begin
            case (sym_q)
                bus_pkg::SYM_START:
                begin
                    scl_nxt = (phase == 2'd1) || (phase == 2'd2);
                    sda_nxt = phase[1];            // falls with scl high
                end
                bus_pkg::SYM_STOP:
                begin
                    scl_nxt = (phase != 2'd0);
                    sda_nxt = !phase[1];           // rises with scl high
                end
                bus_pkg::SYM_TX:
                begin
                    scl_nxt = (phase == 2'd1) || (phase == 2'd2);
                    sda_nxt = !tx_q;
                end
                default:
                begin
                    scl_nxt = (phase == 2'd1) || (phase == 2'd2);
                    sda_nxt = 1'b0;                // released for the slave
                end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            phase   <= 2'd0;
            div     <= '0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            scl     <= scl_nxt;
            sda_low <= sda_nxt;
            if (!active)
            begin
                if (bus.go)
                begin
                    active <= 1'b1;
                    phase  <= 2'd0;
                    div    <= '0;
                end
            end
            else if (div == DIV_LAST)
            begin
                div   <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd3)
                    active <= 1'b0;
            end
            else
                div <= div + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (bus.go && !active)
        begin
            sym_q <= bus.sym;
            tx_q  <= bus.tx_bit;
        end
        if (active && phase == 2'd2 && div == DIV_LAST)
            bus.rx_bit <= sda_in;    // end of the high quarter
    end

    assign bus.done = active && (phase == 2'd3) && (div == DIV_LAST);

endmodule

// File: hw/byte_shifter.sv
`timescale 1ns/100ps

module byte_shifter
(
    input  logic        CLK,
    input  logic        RESET,
    byte_if.shifter     cmd,
    bit_if.shifter      bits
);

    logic                           busy_q;
    logic [3:0]                     cnt;       // symbols finished in this op
    logic [bus_pkg::DATA_W-1:0]     sreg;
    ctrl_pkg::byte_op_t             op_q;
    logic                           last_q;
    logic                           single;

    assign single = (op_q == ctrl_pkg::OP_START) || (op_q == ctrl_pkg::OP_STOP);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy_q   <= 1'b0;
            cnt      <= 4'd0;
            bits.go  <= 1'b0;
            cmd.done <= 1'b0;
        end
        else
        begin
            bits.go  <= 1'b0;
            cmd.done <= 1'b0;
            if (!busy_q)
            begin
                if (cmd.go)
                begin
                    busy_q  <= 1'b1;
                    cnt     <= 4'd0;
                    bits.go <= 1'b1;
                end
            end
            else if (bits.done)
            begin
                if (single || cnt == 4'd8)
                begin
                    busy_q   <= 1'b0;
                    cmd.done <= 1'b1;
                end
                else
                begin
                    cnt     <= cnt + 4'd1;
                    bits.go <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (!busy_q && cmd.go)
        begin
            op_q        <= cmd.op;
            last_q      <= cmd.last;
            sreg        <= cmd.tx_byte;
            bits.tx_bit <= cmd.tx_byte[7];    // msb first
            case (cmd.op)
                ctrl_pkg::OP_START: bits.sym <= bus_pkg::SYM_START;
                ctrl_pkg::OP_STOP:  bits.sym <= bus_pkg::SYM_STOP;
                ctrl_pkg::OP_SEND:  bits.sym <= bus_pkg::SYM_TX;
                default:            bits.sym <= bus_pkg::SYM_RX;
            endcase
        end
        else if (busy_q && bits.done && !single && cnt < 4'd8)
        begin
            sreg <= {sreg[6:0], bits.rx_bit};
            if (op_q == ctrl_pkg::OP_SEND)
            begin
                bits.sym    <= (cnt == 4'd7) ? bus_pkg::SYM_RX : bus_pkg::SYM_TX;
                bits.tx_bit <= sreg[6];
            end
            else
            begin
                // master ack after the eighth bit
                bits.sym    <= (cnt == 4'd7) ? bus_pkg::SYM_TX : bus_pkg::SYM_RX;
                bits.tx_bit <= last_q;
            end
        end
        if (busy_q && bits.done && op_q == ctrl_pkg::OP_SEND && cnt == 4'd8)
            cmd.ack_bit <= bits.rx_bit;
    end

    assign cmd.rx_byte = sreg;

endmodule

// File: hw/eeprom_ctrl.sv
`timescale 1ns/100ps

module eeprom_ctrl
(
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            wr,
    input  logic                            rd,
    input  logic [bus_pkg::ADDR_W-1:0]      addr,
    input  logic [bus_pkg::DATA_W-1:0]      wr_data,
    output logic [bus_pkg::DATA_W-1:0]      rd_data,
    output logic                            done,
    output logic                            nack,
    output logic                            busy,
    byte_if.ctrl                            ops
);

    ctrl_pkg::main_state_t          state;
    logic [bus_pkg::ADDR_W-1:0]     addr_q;
    logic [bus_pkg::DATA_W-1:0]     data_q;
    logic                           rd_q;
    logic                           err_q;    // some byte went unacked
    logic                           sending;

    assign sending = (state == ctrl_pkg::ST_CTRL_W) || (state == ctrl_pkg::ST_ADDR) ||
                     (state == ctrl_pkg::ST_DATA_W) || (state == ctrl_pkg::ST_CTRL_R);

    // byte operation for the current state
    always_comb
    begin
        ops.op      = ctrl_pkg::OP_STOP;
        ops.tx_byte = '0;
        ops.last    = 1'b0;
        case (state)
            ctrl_pkg::ST_START,
            ctrl_pkg::ST_RESTART: ops.op = ctrl_pkg::OP_START;
            ctrl_pkg::ST_CTRL_W:
            begin
                ops.op      = ctrl_pkg::OP_SEND;
                ops.tx_byte = {bus_pkg::DEV_CODE, addr_q[bus_pkg::ADDR_W-1:8], 1'b0};
            end
            ctrl_pkg::ST_ADDR:
            begin
                ops.op      = ctrl_pkg::OP_SEND;
                ops.tx_byte = addr_q[7:0];
            end
            ctrl_pkg::ST_DATA_W:
            begin
                ops.op      = ctrl_pkg::OP_SEND;
                ops.tx_byte = data_q;
            end
            ctrl_pkg::ST_CTRL_R:
            begin
                ops.op      = ctrl_pkg::OP_SEND;
                ops.tx_byte = {bus_pkg::DEV_CODE, addr_q[bus_pkg::ADDR_W-1:8], 1'b1};
            end
            ctrl_pkg::ST_DATA_R:
            begin
                ops.op   = ctrl_pkg::OP_RECV;
                ops.last = 1'b1;    // single byte read ends with nack
            end
            default: ops.op = ctrl_pkg::OP_STOP;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= ctrl_pkg::ST_IDLE;
            ops.go <= 1'b0;
            err_q  <= 1'b0;
        end
        else
        begin
            ops.go <= 1'b0;
            if (state == ctrl_pkg::ST_IDLE)
            begin
                if (wr || rd)
                begin
                    state  <= ctrl_pkg::ST_START;
                    ops.go <= 1'b1;
                    err_q  <= 1'b0;
                end
            end
            else if (state == ctrl_pkg::ST_DONE)
                state <= ctrl_pkg::ST_IDLE;
            else if (ops.done)
            begin
                ops.go <= 1'b1;
                if (sending && ops.ack_bit)
                    err_q <= 1'b1;
                case (state)
                    ctrl_pkg::ST_START:   state <= ctrl_pkg::ST_CTRL_W;
                    ctrl_pkg::ST_CTRL_W:
                        state <= ops.ack_bit ? ctrl_pkg::ST_STOP : ctrl_pkg::ST_ADDR;
                    ctrl_pkg::ST_ADDR:
                        if (ops.ack_bit)
                            state <= ctrl_pkg::ST_STOP;
                        else if (rd_q)
                            state <= ctrl_pkg::ST_RESTART;
                        else
                            state <= ctrl_pkg::ST_DATA_W;
                    ctrl_pkg::ST_DATA_W:  state <= ctrl_pkg::ST_STOP;
                    ctrl_pkg::ST_RESTART: state <= ctrl_pkg::ST_CTRL_R;
                    ctrl_pkg::ST_CTRL_R:
                        state <= ops.ack_bit ? ctrl_pkg::ST_STOP : ctrl_pkg::ST_DATA_R;
                    ctrl_pkg::ST_DATA_R:  state <= ctrl_pkg::ST_STOP;
                    default:
                    begin
                        state  <= ctrl_pkg::ST_DONE;   // stop sent
                        ops.go <= 1'b0;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == ctrl_pkg::ST_IDLE && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= wr_data;
            rd_q   <= !wr;    // write wins
        end
        if (state == ctrl_pkg::ST_DATA_R && ops.done)
            rd_data <= ops.rx_byte;
    end

    assign done = (state == ctrl_pkg::ST_DONE);
    assign nack = done && err_q;
    assign busy = (state != ctrl_pkg::ST_IDLE);

endmodule

// File: hw/eeprom_top.sv
`timescale 1ns/100ps

module eeprom_top
#(
    parameter int CLK_DIV = 2    // clk cycles per quarter scl
)
(
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            wr,
    input  logic                            rd,
    input  logic [bus_pkg::ADDR_W-1:0]      addr,
    input  logic [bus_pkg::DATA_W-1:0]      wr_data,
    output logic [bus_pkg::DATA_W-1:0]      rd_data,
    output logic                            done,
    output logic                            nack,
    output logic                            busy,
    output logic                            scl,
    output logic                            sda_low,
    input  logic                            sda_in
);

    byte_if ops_if ();
    bit_if  bits_if ();

    eeprom_ctrl u_ctrl
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .done    (done),
        .nack    (nack),
        .busy    (busy),
        .ops     (ops_if.ctrl)
    );

    byte_shifter u_shifter
    (
        .CLK   (CLK),
        .RESET (RESET),
        .cmd   (ops_if.shifter),
        .bits  (bits_if.shifter)
    );

    bit_engine #(.CLK_DIV(CLK_DIV)) u_engine
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .bus     (bits_if.engine),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda_in)
    );

endmodule

// File: test/eeprom_model.sv
`timescale 1ns/100ps

module eeprom_model
(
    input  logic    scl,
    input  logic    sda,
    output logic    sda_pull
);

    logic [7:0] mem [0:2047];
    logic [7:0] ctrl_log [$];    // every control byte seen
    logic       force_nack;      // refuse the control byte

    logic [7:0] sreg;
    logic [7:0] rbyte;
    logic [7:0] word_addr;
    logic [7:0] data_byte;
    logic [2:0] page;
    int         bit_cnt;
    int         byte_idx;
    logic       ignoring;
    logic       tx_mode;     // slave drives a data byte
    logic       start_tx;
    logic       have_data;

    initial
    begin
        sda_pull   = 1'b0;
        force_nack = 1'b0;
        ignoring   = 1'b1;
        tx_mode    = 1'b0;
        start_tx   = 1'b0;
        have_data  = 1'b0;
        word_addr  = 8'h00;
        page       = 3'd0;
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a[7:0] ^ {a[10:8], a[10:8], a[10:9]}) + 8'h5a;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            bit_cnt   = 0;
            byte_idx  = 0;
            ignoring  = 1'b0;
            tx_mode   = 1'b0;
            start_tx  = 1'b0;
            have_data = 1'b0;
            sda_pull  = 1'b0;
        end
    end

    // stop commits a pending byte write
    always @(posedge sda)
    begin
        if (scl === 1'b1 && !ignoring)
        begin
            if (have_data)
                mem[{page, word_addr}] = data_byte;
            have_data = 1'b0;
            ignoring  = 1'b1;
        end
    end

    always @(posedge scl)
    begin
        if (!ignoring)
        begin
            if (bit_cnt < 8 && !tx_mode)
                sreg = {sreg[6:0], sda};
            bit_cnt++;
        end
    end

    always @(negedge scl)
    begin
        if (!ignoring)
        begin
            if (bit_cnt == 8)
            begin
                if (tx_mode)
                    sda_pull = 1'b0;    // master answers
                else
                begin
                    sda_pull = 1'b1;
                    case (byte_idx)
                        0:
                        begin
                            ctrl_log.push_back(sreg);
                            page = sreg[3:1];
                            if (force_nack)
                            begin
                                sda_pull = 1'b0;
                                ignoring = 1'b1;
                            end
                            else if (sreg[0])
                            begin
                                start_tx = 1'b1;
                                rbyte    = mem[{page, word_addr}];
                            end
                        end
                        1: word_addr = sreg;
                        2:
                        begin
                            data_byte = sreg;
                            have_data = 1'b1;
                        end
                        default: ;
                    endcase
                    byte_idx++;
                end
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt  = 0;
                sda_pull = 1'b0;
                if (start_tx)
                begin
                    start_tx = 1'b0;
                    tx_mode  = 1'b1;
                    sda_pull = !rbyte[7];
                end
                else if (tx_mode)
                begin
                    tx_mode  = 1'b0;    // single byte only
                    ignoring = 1'b1;
                end
            end
            else if (tx_mode)
                sda_pull = !rbyte[7 - bit_cnt];
        end
    end

endmodule

// File: test/tb_eeprom.sv
`timescale 1ns/100ps

module tb_eeprom;

    logic           CLK;
    logic           RESET;
    logic           wr;
    logic           rd;
    logic [10:0]    addr;
    logic [7:0]     wr_data;
    logic [7:0]     rd_data;
    logic           done;
    logic           nack;
    logic           busy;
    logic           scl;
    logic           sda_low;
    logic           sda;
    logic           model_pull;

    logic [7:0]     shadow [0:2047];
    logic [31:0]    lfsr_state;
    int             checks;
    int             errors;
    int             done_count;
    logic [10:0]    addrs [0:31];
    int             order [0:31];

    localparam int TIMEOUT = 4000;

    assign sda = !(sda_low || model_pull);    // open drain

    eeprom_top #(.CLK_DIV(1)) UUT
    (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .done    (done),
        .nack    (nack),
        .busy    (busy),
        .scl     (scl),
        .sda_low (sda_low),
        .sda_in  (sda)
    );

    eeprom_model MODEL
    (
        .scl      (scl),
        .sda      (sda),
        .sda_pull (model_pull)
    );

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        if (!RESET && done)
            done_count++;
    end

    function automatic logic [7:0] expected_read(input logic [10:0] a);
        return shadow[a];
    endfunction

    // 1010 with block select and r/w
    function automatic logic [7:0] expected_ctrl(input logic [10:0] a, input logic rw);
        return {4'b1010, a[10:8], rw};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        $display("%s: %0d errors", name, errors - err0);
    endtask

    task automatic start_cmd(input logic is_wr, input logic [10:0] a, input logic [7:0] d);
        @(posedge CLK);
        wr      <= is_wr;
        rd      <= !is_wr;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_done(output logic ok, output logic [7:0] data, output logic nk);
        ok = 1'b0;
        for (int n = 0; n < TIMEOUT && !ok; n++)
        begin
            @(negedge CLK);
            if (done)
            begin
                ok   = 1'b1;
                data = rd_data;
                nk   = nack;
            end
        end
        if (!ok)
        begin
            errors++;
            $display("timeout waiting for done");
        end
    endtask

    task automatic check_idle();
        @(negedge CLK);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_low", 32'(sda_low), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("nack", 32'(nack), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic do_write(input logic [10:0] a, input logic [7:0] d, input logic exp_nack);
        int n0;
        logic ok;
        logic [7:0] data;
        logic nk;
        n0 = MODEL.ctrl_log.size();
        start_cmd(1'b1, a, d);
        wait_done(ok, data, nk);
        if (ok)
        begin
            check_value("nack", 32'(nk), 32'(exp_nack));
            check_value("ctrl_log size", 32'(MODEL.ctrl_log.size()), 32'(n0 + 1));
            if (MODEL.ctrl_log.size() > n0)
                check_value("ctrl byte", 32'(MODEL.ctrl_log[n0]), 32'(expected_ctrl(a, 1'b0)));
        end
        if (!exp_nack)
            shadow[a] = d;
        check_idle();
    endtask

    task automatic do_read(input logic [10:0] a);
        int n0;
        logic ok;
        logic [7:0] data;
        logic nk;
        n0 = MODEL.ctrl_log.size();
        start_cmd(1'b0, a, 8'h00);
        wait_done(ok, data, nk);
        if (ok)
        begin
            check_value("nack", 32'(nk), 32'd0);
            check_value("rd_data", 32'(data), 32'(expected_read(a)));
            check_value("ctrl_log size", 32'(MODEL.ctrl_log.size()), 32'(n0 + 2));
            if (MODEL.ctrl_log.size() > n0 + 1)
            begin
                check_value("ctrl byte", 32'(MODEL.ctrl_log[n0]), 32'(expected_ctrl(a, 1'b0)));
                check_value("ctrl byte", 32'(MODEL.ctrl_log[n0 + 1]),
                            32'(expected_ctrl(a, 1'b1)));
            end
        end
        check_idle();
    endtask

    initial
    begin
        int err0;
        int dc0;
        int j;
        int tmp;
        logic [31:0] r;
        logic [10:0] a;
        logic ok;
        logic [7:0] data;
        logic nk;

        RESET      = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = '0;
        wr_data    = '0;
        checks     = 0;
        errors     = 0;
        done_count = 0;
        lfsr_state = 32'h2516;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'(i[7:0] ^ {i[10:8], i[10:8], i[10:9]}) + 8'h5a;
        repeat (8) @(posedge CLK);
        RESET <= 1'b0;

        err0 = errors;
        check_idle();
        end_test("reset and idle", err0);

        err0 = errors;
        do_write(11'h2a5, 8'h3c, 1'b0);
        do_read(11'h2a5);
        end_test("write then read back", err0);

        err0 = errors;
        for (int i = 0; i < 32; i++)
        begin
            take_bits(11, r);
            a = r[10:0];
            if (i % 4 == 3)
            begin
                a = {r[2:0], addrs[i - 1][7:0]};    // same word in another block
                if (a[10:8] == addrs[i - 1][10:8])
                    a[10:8] = a[10:8] ^ 3'd1;
            end
            take_bits(8, r);
            addrs[i] = a;
            do_write(a, r[7:0], 1'b0);
        end
        for (int i = 0; i < 32; i++)
            order[i] = i;
        for (int i = 31; i > 0; i--)
        begin
            take_bits(5, r);
            j = int'(r % (i + 1));
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < 32; i++)
            do_read(addrs[order[i]]);
        end_test("random traffic", err0);

        err0 = errors;
        MODEL.force_nack = 1'b1;
        do_write(11'h513, ~shadow[11'h513], 1'b1);
        MODEL.force_nack = 1'b0;
        do_read(11'h513);
        end_test("slave nack", err0);

        err0 = errors;
        dc0 = done_count;
        start_cmd(1'b1, 11'h0f0, 8'ha7);
        repeat (20) @(posedge CLK);
        @(negedge CLK);
        check_value("busy", 32'(busy), 32'd1);
        start_cmd(1'b1, 11'h1f1, ~shadow[11'h1f1]);
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        check_value("busy", 32'(busy), 32'd1);
        start_cmd(1'b0, 11'h1f1, 8'h00);
        wait_done(ok, data, nk);
        shadow[11'h0f0] = 8'ha7;
        repeat (300) @(posedge CLK);    // room for a stray command
        check_value("done_count", 32'(done_count), 32'(dc0 + 1));
        check_value("mem[0f0]", 32'(MODEL.mem[11'h0f0]), 32'(shadow[11'h0f0]));
        check_value("mem[1f1]", 32'(MODEL.mem[11'h1f1]), 32'(shadow[11'h1f1]));
        check_idle();
        end_test("strobes while busy", err0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: tb.f
hw/bus_pkg.sv
hw/ctrl_pkg.sv
hw/eeprom_ifs.sv
hw/bit_engine.sv
hw/byte_shifter.sv
hw/eeprom_ctrl.sv
hw/eeprom_top.sv
test/eeprom_model.sv
test/tb_eeprom.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
TOP       ?= tb_eeprom
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
